// File: ikari_video_top.f
hw/ikari_video_pkg.sv
hw/axil_reg_fsm.sv
hw/video_regs.sv
hw/video_timing.sv
hw/scroll_coord.sv
hw/layer_mixer.sv
hw/ikari_video_top.sv
tests/ikari_video_checker.sv
tests/ikari_video_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the video core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
EXE=ikari_video_sim

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module ikari_video_tb \
    -f ikari_video_top.f \
    --Mdir "$BUILD_DIR" -o "$EXE"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: tests/ikari_video_tb.sv
// Directed testbench for the video core; the timing test must start at reset release
// Stimulus changes on the rising edge, outputs are checked on the falling edge
`timescale 1ns/1ps

module ikari_video_tb import ikari_video_pkg::*; ();

    localparam int WAIT_LIMIT  = 64;
    localparam int HOLD_CYCLES = 6;
    localparam int FRAME_LIMIT = H_TOTAL * V_TOTAL;

    logic                  clk;
    logic                  rst_n;
    logic                  awvalid;
    logic [AXI_ADDR_W-1:0] awaddr;
    logic                  awready;
    logic                  wvalid;
    logic [AXI_DATA_W-1:0] wdata;
    logic                  wready;
    logic                  bvalid;
    logic [1:0]            bresp;
    logic                  bready;
    logic                  arvalid;
    logic [AXI_ADDR_W-1:0] araddr;
    logic                  arready;
    logic                  rvalid;
    logic [AXI_DATA_W-1:0] rdata;
    logic [1:0]            rresp;
    logic                  rready;
    layer_pix_t            layers;
    video_pos_t            pos;
    logic [COORD_W-1:0]    bg_x;
    logic [COORD_W-1:0]    bg_y;
    color_t                color;
    integer                seed;
    int                    errors;
    int                    tests;

    ikari_video_top i_dut (
        .i_clk(clk),
        .i_rst_n(rst_n),
        .i_awvalid(awvalid),
        .i_awaddr(awaddr),
        .o_awready(awready),
        .i_wvalid(wvalid),
        .i_wdata(wdata),
        .o_wready(wready),
        .o_bvalid(bvalid),
        .o_bresp(bresp),
        .i_bready(bready),
        .i_arvalid(arvalid),
        .i_araddr(araddr),
        .o_arready(arready),
        .o_rvalid(rvalid),
        .o_rdata(rdata),
        .o_rresp(rresp),
        .i_rready(rready),
        .i_layers(layers),
        .o_pos(pos),
        .o_bg_x(bg_x),
        .o_bg_y(bg_y),
        .o_color(color)
    );

    bind ikari_video_top ikari_video_checker i_checker (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_bvalid(o_bvalid),
        .i_bready(i_bready),
        .i_rvalid(o_rvalid),
        .i_rready(i_rready),
        .i_rdata(o_rdata),
        .i_pos(o_pos),
        .i_color(o_color)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        errors++;
        $display("Fail %s: got 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
    endtask

    task automatic timed_out(input string what);
        errors++;
        $display("Timeout: %s did not happen in time at %0t ns", what, $time);
    endtask

    task automatic finish_test(input string name, input int start_err);
        tests++;
        $display("Test %s finished with %0d errors", name, errors - start_err);
    endtask

    // Storage width of each register
    function automatic logic [31:0] reg_mask(input logic [AXI_ADDR_W-1:0] addr);
        case (addr)
            ADDR_SCROLL_X, ADDR_SCROLL_Y: return 32'h0000_01FF;
            ADDR_ATTR, ADDR_LAYER_EN:     return 32'h0000_000F;
            default:                      return 32'h0000_0000;
        endcase
    endfunction

    function automatic logic [COORD_W-1:0] bg_coord(input logic [COORD_W-1:0] p, input logic f,
                                                    input logic [COORD_W-1:0] s);
        logic [COORD_W-1:0] m;
        logic [COORD_W:0]   sum;
        m = p;
        if (f) m = p ^ 9'h0FF;  // Low 8 bits mirrored
        sum = {1'b0, m} + {1'b0, s};
        return sum[COORD_W-1:0];
    endfunction

    // Reference mixer: side, front1, front2, back1
    function automatic color_t mix_ref(input layer_pix_t l, input logic [3:0] en,
                                       input logic [2:0] bank, input logic disp);
        color_t c;
        c.src   = LAYER_NONE;
        c.index = 8'h00;
        if (disp) begin
            if (en[3] && l.side != TRANSPARENT_NIB) begin
                c.src   = LAYER_SIDE;
                c.index = {1'b0, bank, l.side};
            end else if (en[2] && l.front1[3:0] != TRANSPARENT_NIB) begin
                c.src   = LAYER_FRONT1;
                c.index = l.front1;
            end else if (en[1] && l.front2[3:0] != TRANSPARENT_NIB) begin
                c.src   = LAYER_FRONT2;
                c.index = l.front2;
            end else if (en[0]) begin
                c.src   = LAYER_BACK1;
                c.index = l.back1;
            end
        end
        return c;
    endfunction

    // About half of the pixels get a transparent nibble
    function automatic layer_pix_t pick_layers(input logic [31:0] a, input logic [31:0] b);
        layer_pix_t l;
        l.side   = a[0] ? TRANSPARENT_NIB : a[7:4];
        l.front1 = {a[15:12], a[1] ? TRANSPARENT_NIB : a[11:8]};
        l.front2 = {a[23:20], a[2] ? TRANSPARENT_NIB : a[19:16]};
        l.back1  = b[7:0];
        return l;
    endfunction

    task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data);
        int n;
        @(posedge clk);
        awvalid <= 1'b1;
        awaddr  <= addr;
        wvalid  <= 1'b1;
        wdata   <= data;
        bready  <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!awready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!awready) timed_out("write address acceptance");
        if (wready !== 1'b1) mismatch("o_wready", 32'(wready), 32'h1);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!bvalid && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!bvalid) timed_out("write response");
        if (bvalid && bresp !== RESP_OKAY) mismatch("o_bresp", 32'(bresp), 32'(RESP_OKAY));
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic read_expect(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] exp);
        int n;
        @(posedge clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        rready  <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!arready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!arready) timed_out("read address acceptance");
        @(posedge clk);
        arvalid <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!rvalid && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!rvalid) timed_out("read data");
        if (rvalid && rdata !== exp) mismatch($sformatf("o_rdata[0x%02h]", addr), rdata, exp);
        if (rvalid && rresp !== RESP_OKAY) mismatch("o_rresp", 32'(rresp), 32'(RESP_OKAY));
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic write_readback(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data);
        axi_write(addr, data);
        read_expect(addr, data & reg_mask(addr));
    endtask

    task automatic frame_timing();
        int   start_err;
        int   ex;
        int   ey;
        logic e_hb;
        logic e_vb;
        logic e_hs;
        logic e_vs;
        start_err = errors;
        ex = 0;
        ey = 0;
        for (int i = 0; i < FRAME_LIMIT + H_TOTAL; i++) begin
            @(negedge clk);
            e_hb = (ex >= H_ACTIVE);
            e_vb = (ey >= V_ACTIVE);
            e_hs = (ex >= HSYNC_START) && (ex < HSYNC_END);
            e_vs = (ey >= VSYNC_START) && (ey < VSYNC_END);
            if (pos.x !== COORD_W'(ex)) mismatch("o_pos.x", 32'(pos.x), 32'(ex));
            if (pos.y !== COORD_W'(ey)) mismatch("o_pos.y", 32'(pos.y), 32'(ey));
            if (pos.hblank !== e_hb) mismatch("o_pos.hblank", 32'(pos.hblank), 32'(e_hb));
            if (pos.vblank !== e_vb) mismatch("o_pos.vblank", 32'(pos.vblank), 32'(e_vb));
            if (pos.hsync !== e_hs) mismatch("o_pos.hsync", 32'(pos.hsync), 32'(e_hs));
            if (pos.vsync !== e_vs) mismatch("o_pos.vsync", 32'(pos.vsync), 32'(e_vs));
            if (pos.disp !== (!e_hb && !e_vb)) begin
                mismatch("o_pos.disp", 32'(pos.disp), 32'(!e_hb && !e_vb));
            end
            ex++;
            if (ex == H_TOTAL) begin  // Line wrap
                ex = 0;
                ey = (ey == V_TOTAL - 1) ? 0 : ey + 1;
            end
        end
        finish_test("timing", start_err);
    endtask

    task automatic reset_readback();
        int start_err;
        start_err = errors;
        read_expect(ADDR_SCROLL_X, 32'h0);
        read_expect(ADDR_SCROLL_Y, 32'h0);
        read_expect(ADDR_ATTR, 32'h0);
        read_expect(ADDR_LAYER_EN, 32'hF);
        write_readback(ADDR_SCROLL_X, 32'hFFFF_F1A5);
        write_readback(ADDR_SCROLL_Y, 32'h0000_02C3);
        write_readback(ADDR_ATTR, 32'hABCD_EF0B);
        write_readback(ADDR_LAYER_EN, 32'h0000_0035);
        write_readback(8'h10, 32'hFFFF_FFFF);  // Unmapped
        finish_test("reset_readback", start_err);
    endtask

    task automatic scroll_coords();
        int                 start_err;
        logic [31:0]        r;
        logic [COORD_W-1:0] sx;
        logic [COORD_W-1:0] sy;
        logic [COORD_W-1:0] ebx;
        logic [COORD_W-1:0] eby;
        logic               f;
        video_pos_t         prev;
        start_err = errors;
        for (int k = 0; k < 6; k++) begin
            r  = $random(seed);
            sx = r[8:0];
            sy = r[24:16];
            f  = k[0];
            axi_write(ADDR_SCROLL_X, 32'(sx));
            axi_write(ADDR_SCROLL_Y, 32'(sy));
            axi_write(ADDR_ATTR, {31'b0, f});
            @(negedge clk);
            prev = pos;
            for (int i = 0; i < 800; i++) begin
                @(negedge clk);
                ebx = bg_coord(prev.x, f, sx);
                eby = bg_coord(prev.y, f, sy);
                if (bg_x !== ebx) mismatch("o_bg_x", 32'(bg_x), 32'(ebx));
                if (bg_y !== eby) mismatch("o_bg_y", 32'(bg_y), 32'(eby));
                prev = pos;
            end
        end
        finish_test("scroll", start_err);
    endtask

    task automatic layer_priority();
        int          start_err;
        logic [31:0] r;
        logic [3:0]  en;
        logic [2:0]  bank;
        layer_pix_t  prev_layers;
        logic        prev_disp;
        color_t      exp_c;
        start_err = errors;
        for (int k = 0; k < 8; k++) begin
            r    = $random(seed);
            en   = r[3:0];
            bank = r[6:4];
            axi_write(ADDR_LAYER_EN, 32'(en));
            axi_write(ADDR_ATTR, {28'b0, bank, 1'b0});
            for (int i = 0; i < 400; i++) begin
                @(posedge clk);
                layers <= pick_layers($random(seed), $random(seed));
                @(negedge clk);
                if (i > 0) begin
                    exp_c = mix_ref(prev_layers, en, bank, prev_disp);
                    if (color !== exp_c) mismatch("o_color", 32'(color), 32'(exp_c));
                end
                prev_layers = layers;
                prev_disp   = pos.disp;
            end
        end
        finish_test("priority", start_err);
    endtask

    task automatic side_bank_index();
        int start_err;
        int n;
        start_err = errors;
        axi_write(ADDR_LAYER_EN, 32'h0000_000F);
        axi_write(ADDR_ATTR, 32'h0000_000A);  // Bank 5, no flip
        @(posedge clk);
        layers <= '{side: 4'h7, front1: 8'h12, front2: 8'h34, back1: 8'h56};
        n = 0;
        @(negedge clk);
        while (!pos.disp && n < FRAME_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!pos.disp) begin
            timed_out("display enable");
        end else begin
            @(negedge clk);
            if (color.src !== LAYER_SIDE) mismatch("o_color.src", 32'(color.src), 32'(LAYER_SIDE));
            if (color.index[6:4] !== 3'd5) mismatch("o_color.index[6:4]", 32'(color.index[6:4]), 5);
            if (color.index !== 8'h57) mismatch("o_color.index", 32'(color.index), 32'h57);
        end
        finish_test("side_bank", start_err);
    endtask

    task automatic response_backpressure();
        int start_err;
        int n;
        start_err = errors;
        @(posedge clk);
        awvalid <= 1'b1;
        awaddr  <= ADDR_SCROLL_X;
        wvalid  <= 1'b1;
        wdata   <= 32'h0000_0055;
        bready  <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!awready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!awready) timed_out("write address acceptance");
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        arvalid <= 1'b1;  // Must wait behind the write response
        araddr  <= ADDR_LAYER_EN;
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            @(negedge clk);
            if (bvalid !== 1'b1) mismatch("o_bvalid", 32'(bvalid), 32'h1);
            if (arready !== 1'b0) mismatch("o_arready", 32'(arready), 32'h0);
        end
        @(posedge clk);
        arvalid <= 1'b0;
        bready  <= 1'b1;
        n = 0;
        @(negedge clk);
        while (bvalid && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (bvalid) timed_out("write response completion");
        @(posedge clk);
        bready  <= 1'b0;
        arvalid <= 1'b1;
        araddr  <= ADDR_SCROLL_X;
        rready  <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!arready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!arready) timed_out("read address acceptance");
        @(posedge clk);
        arvalid <= 1'b0;
        awvalid <= 1'b1;  // Must not land while the read is pending
        awaddr  <= ADDR_SCROLL_X;
        wvalid  <= 1'b1;
        wdata   <= 32'h0000_01AA;
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            @(negedge clk);
            if (rvalid !== 1'b1) mismatch("o_rvalid", 32'(rvalid), 32'h1);
            if (rdata !== 32'h55) mismatch("o_rdata", rdata, 32'h55);
            if (awready !== 1'b0) mismatch("o_awready", 32'(awready), 32'h0);
        end
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        rready  <= 1'b1;
        n = 0;
        @(negedge clk);
        while (rvalid && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (rvalid) timed_out("read response completion");
        @(posedge clk);
        rready <= 1'b0;
        read_expect(ADDR_SCROLL_X, 32'h55);
        finish_test("backpressure", start_err);
    endtask

    initial begin
        rst_n   = 1'b0;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        layers  = '0;
        seed    = 32'h3d61;
        errors  = 0;
        tests   = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        frame_timing();  // Counts from reset release
        reset_readback();
        scroll_coords();
        layer_priority();
        side_bank_index();
        response_backpressure();
        $display("Tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: tests/ikari_video_checker.sv
// Concurrent checks on the AXI response channels and the video outputs
// Bound to ikari_video_top; all properties are off while reset is low
`timescale 1ns/1ps

module ikari_video_checker import ikari_video_pkg::*; (
    input logic                  i_clk,
    input logic                  i_rst_n,
    input logic                  i_bvalid,
    input logic                  i_bready,
    input logic                  i_rvalid,
    input logic                  i_rready,
    input logic [AXI_DATA_W-1:0] i_rdata,
    input video_pos_t            i_pos,
    input color_t                i_color
);

    // Write response held until taken
    bvalid_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_bvalid && !i_bready |=> i_bvalid)
        else $error("bvalid dropped before bready");

    rvalid_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata))
        else $error("rvalid or rdata changed before rready");

    // Mixer output is one cycle behind disp
    blank_color: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_pos.disp |=> i_color.src == LAYER_NONE)
        else $error("o_color not LAYER_NONE after disp low");

    sync_in_blank: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pos.hsync |-> i_pos.hblank)
        else $error("hsync outside hblank");

endmodule

// File: hw/ikari_video_top.sv
// Display core top: AXI4-Lite register access, timing, scroll and mixer
// Layer pixels come in already fetched, aligned with o_pos
`timescale 1ns/1ps

module ikari_video_top import ikari_video_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_awvalid,
    input  logic [AXI_ADDR_W-1:0] i_awaddr,
    output logic                  o_awready,
    input  logic                  i_wvalid,
    input  logic [AXI_DATA_W-1:0] i_wdata,
    output logic                  o_wready,
    output logic                  o_bvalid,
    output logic [1:0]            o_bresp,
    input  logic                  i_bready,
    input  logic                  i_arvalid,
    input  logic [AXI_ADDR_W-1:0] i_araddr,
    output logic                  o_arready,
    output logic                  o_rvalid,
    output logic [AXI_DATA_W-1:0] o_rdata,
    output logic [1:0]            o_rresp,
    input  logic                  i_rready,
    input  layer_pix_t            i_layers,
    output video_pos_t            o_pos,
    output logic [COORD_W-1:0]    o_bg_x,
    output logic [COORD_W-1:0]    o_bg_y,
    output color_t                o_color
);

    reg_wr_t               reg_wr;
    reg_addr_e             rd_target;
    logic [AXI_DATA_W-1:0] rd_data;
    video_cfg_t            cfg;
    video_pos_t            pos;

    axil_reg_fsm ik_axil (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_awvalid(i_awvalid),
        .i_awaddr(i_awaddr),
        .o_awready(o_awready),
        .i_wvalid(i_wvalid),
        .i_wdata(i_wdata),
        .o_wready(o_wready),
        .o_bvalid(o_bvalid),
        .o_bresp(o_bresp),
        .i_bready(i_bready),
        .i_arvalid(i_arvalid),
        .i_araddr(i_araddr),
        .o_arready(o_arready),
        .o_rvalid(o_rvalid),
        .o_rdata(o_rdata),
        .o_rresp(o_rresp),
        .i_rready(i_rready),
        .i_rd_data(rd_data),
        .o_reg_wr(reg_wr),
        .o_rd_target(rd_target)
    );

    video_regs ik_regs (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_reg_wr(reg_wr),
        .i_rd_target(rd_target),
        .o_rd_data(rd_data),
        .o_cfg(cfg)
    );

    video_timing ik_timing (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .o_pos(pos)
    );

    scroll_coord ik_scroll (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_pos(pos),
        .i_cfg(cfg),
        .o_bg_x(o_bg_x),
        .o_bg_y(o_bg_y)
    );

    layer_mixer ik_mixer (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_layers(i_layers),
        .i_cfg(cfg),
        .i_disp(pos.disp),
        .o_color(o_color)
    );

    assign o_pos = pos;

endmodule

// File: hw/layer_mixer.sv
// Fixed priority side > front1 > front2 > back1, registered one cycle
// Back1 is always opaque; output is forced to no layer outside disp
`timescale 1ns/1ps

module layer_mixer import ikari_video_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  layer_pix_t i_layers,
    input  video_cfg_t i_cfg,
    input  logic       i_disp,
    output color_t     o_color
);

    logic   side_hit;
    logic   front1_hit;
    logic   front2_hit;
    logic   back1_hit;
    color_t color_d;

    // Enable bit and transparency test per layer
    assign side_hit   = i_cfg.layer_en[3] && (i_layers.side != TRANSPARENT_NIB);
    assign front1_hit = i_cfg.layer_en[2] && (i_layers.front1[3:0] != TRANSPARENT_NIB);
    assign front2_hit = i_cfg.layer_en[1] && (i_layers.front2[3:0] != TRANSPARENT_NIB);
    assign back1_hit  = i_cfg.layer_en[0];

    always_comb begin
        color_d.src   = LAYER_NONE;
        color_d.index = '0;
        if (!i_disp) begin
            color_d.src = LAYER_NONE;
        end else if (side_hit) begin
            color_d.src   = LAYER_SIDE;
            color_d.index = {1'b0, i_cfg.side_bank, i_layers.side};  // Bank in bits 6:4
        end else if (front1_hit) begin
            color_d.src   = LAYER_FRONT1;
            color_d.index = i_layers.front1;
        end else if (front2_hit) begin
            color_d.src   = LAYER_FRONT2;
            color_d.index = i_layers.front2;
        end else if (back1_hit) begin
            color_d.src   = LAYER_BACK1;
            color_d.index = i_layers.back1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_color.src   <= LAYER_NONE;
            o_color.index <= '0;
        end else begin
            o_color <= color_d;
        end
    end

endmodule

// File: hw/scroll_coord.sv
// Background map coordinate, one cycle behind the screen position
// Flip mirrors the low 8 bits only; the sum wraps at 512
`timescale 1ns/1ps

module scroll_coord import ikari_video_pkg::*; (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  video_pos_t         i_pos,
    input  video_cfg_t         i_cfg,
    output logic [COORD_W-1:0] o_bg_x,
    output logic [COORD_W-1:0] o_bg_y
);

    logic [COORD_W-1:0] x_flip;
    logic [COORD_W-1:0] y_flip;

    always_comb begin
        x_flip = i_pos.x;
        y_flip = i_pos.y;
        if (i_cfg.flip) begin
            x_flip[7:0] = ~i_pos.x[7:0];
            y_flip[7:0] = ~i_pos.y[7:0];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_bg_x <= '0;
            o_bg_y <= '0;
        end else begin
            o_bg_x <= x_flip + i_cfg.scroll_x;  // Natural 9-bit wrap
            o_bg_y <= y_flip + i_cfg.scroll_y;
        end
    end

endmodule

// File: hw/video_timing.sv
// Free-running pixel and line counters, one pixel per i_clk
// Blank, sync and disp are decoded combinationally from the counters
`timescale 1ns/1ps

module video_timing import ikari_video_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    output video_pos_t o_pos
);

    logic [COORD_W-1:0] x_q;
    logic [COORD_W-1:0] y_q;
    logic               x_last;
    logic               y_last;
    logic               hblank;
    logic               vblank;

    assign x_last = (x_q == COORD_W'(H_TOTAL - 1));
    assign y_last = (y_q == COORD_W'(V_TOTAL - 1));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            x_q <= '0;
            y_q <= '0;
        end else begin
            if (x_last) begin
                x_q <= '0;
                // Line advances on horizontal wrap
                if (y_last) begin
                    y_q <= '0;
                end else begin
                    y_q <= y_q + 1'b1;
                end
            end else begin
                x_q <= x_q + 1'b1;
            end
        end
    end

    assign hblank = (x_q >= COORD_W'(H_ACTIVE));
    assign vblank = (y_q >= COORD_W'(V_ACTIVE));

    always_comb begin
        o_pos.x      = x_q;
        o_pos.y      = y_q;
        o_pos.hblank = hblank;
        o_pos.vblank = vblank;
        o_pos.hsync  = (x_q >= COORD_W'(HSYNC_START)) && (x_q < COORD_W'(HSYNC_END));
        o_pos.vsync  = (y_q >= COORD_W'(VSYNC_START)) && (y_q < COORD_W'(VSYNC_END));
        o_pos.disp   = !hblank && !vblank;  // Active area only
    end

endmodule

// File: hw/video_regs.sv
// Video register file; only the low bits of each write are kept
// Reads of unmapped targets return zero
`timescale 1ns/1ps

module video_regs import ikari_video_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  reg_wr_t               i_reg_wr,
    input  reg_addr_e             i_rd_target,
    output logic [AXI_DATA_W-1:0] o_rd_data,
    output video_cfg_t            o_cfg
);

    logic [COORD_W-1:0]     scroll_x_q;
    logic [COORD_W-1:0]     scroll_y_q;
    logic                   flip_q;
    logic [SIDE_BANK_W-1:0] side_bank_q;
    logic [LAYER_EN_W-1:0]  layer_en_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            scroll_x_q  <= '0;
            scroll_y_q  <= '0;
            flip_q      <= 1'b0;
            side_bank_q <= '0;
            layer_en_q  <= LAYER_EN_RESET;  // All layers on
        end else if (i_reg_wr.en) begin
            case (i_reg_wr.target)
                REG_SCROLL_X: scroll_x_q <= i_reg_wr.data[COORD_W-1:0];
                REG_SCROLL_Y: scroll_y_q <= i_reg_wr.data[COORD_W-1:0];
                REG_ATTR: begin
                    flip_q      <= i_reg_wr.data[0];
                    side_bank_q <= i_reg_wr.data[SIDE_BANK_W:1];
                end
                REG_LAYER_EN: layer_en_q <= i_reg_wr.data[LAYER_EN_W-1:0];
                default: ;  // Unmapped, dropped
            endcase
        end
    end

    // Zero-extended readback
    always_comb begin
        o_rd_data = '0;
        case (i_rd_target)
            REG_SCROLL_X: o_rd_data[COORD_W-1:0]    = scroll_x_q;
            REG_SCROLL_Y: o_rd_data[COORD_W-1:0]    = scroll_y_q;
            REG_ATTR:     o_rd_data[SIDE_BANK_W:0]  = {side_bank_q, flip_q};
            REG_LAYER_EN: o_rd_data[LAYER_EN_W-1:0] = layer_en_q;
            default:      o_rd_data = '0;
        endcase
    end

    always_comb begin
        o_cfg.scroll_x  = scroll_x_q;
        o_cfg.scroll_y  = scroll_y_q;
        o_cfg.flip      = flip_q;
        o_cfg.side_bank = side_bank_q;
        o_cfg.layer_en  = layer_en_q;
    end

endmodule

// File: hw/axil_reg_fsm.sv
// AXI4-Lite slave, one transfer at a time; writes win over reads in the same cycle
// Write strobes are ignored and every response is OKAY
`timescale 1ns/1ps

module axil_reg_fsm import ikari_video_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_awvalid,
    input  logic [AXI_ADDR_W-1:0] i_awaddr,
    output logic                  o_awready,
    input  logic                  i_wvalid,
    input  logic [AXI_DATA_W-1:0] i_wdata,
    output logic                  o_wready,
    output logic                  o_bvalid,
    output logic [1:0]            o_bresp,
    input  logic                  i_bready,
    input  logic                  i_arvalid,
    input  logic [AXI_ADDR_W-1:0] i_araddr,
    output logic                  o_arready,
    output logic                  o_rvalid,
    output logic [AXI_DATA_W-1:0] o_rdata,
    output logic [1:0]            o_rresp,
    input  logic                  i_rready,
    input  logic [AXI_DATA_W-1:0] i_rd_data,
    output reg_wr_t               o_reg_wr,
    output reg_addr_e             o_rd_target
);

    axil_state_e           state_q;
    axil_state_e           state_d;
    logic                  wr_go;
    logic                  rd_go;
    logic [AXI_DATA_W-1:0] rdata_q;

    // Address and data must arrive together
    assign wr_go = (state_q == ST_IDLE) && i_awvalid && i_wvalid;
    assign rd_go = (state_q == ST_IDLE) && i_arvalid && !(i_awvalid && i_wvalid);

    assign o_awready = wr_go;
    assign o_wready  = wr_go;
    assign o_arready = rd_go;

    always_comb begin
        o_reg_wr.en     = wr_go;
        o_reg_wr.target = decode_addr(i_awaddr);
        o_reg_wr.data   = i_wdata;
    end

    assign o_rd_target = decode_addr(i_araddr);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (wr_go) begin
                    state_d = ST_WRESP;
                end else if (rd_go) begin
                    state_d = ST_RRESP;
                end
            end
            ST_WRESP: if (i_bready) state_d = ST_IDLE;
            ST_RRESP: if (i_rready) state_d = ST_IDLE;
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Held until the master takes it
    always_ff @(posedge i_clk) begin
        if (rd_go) begin
            rdata_q <= i_rd_data;
        end
    end

    assign o_bvalid = (state_q == ST_WRESP);
    assign o_rvalid = (state_q == ST_RRESP);
    assign o_rdata  = rdata_q;
    assign o_bresp  = RESP_OKAY;
    assign o_rresp  = RESP_OKAY;

endmodule

// File: hw/ikari_video_pkg.sv
// Shared geometry, register map and bus types for the video core
// One i_clk cycle is one pixel; all geometry values are in pixels and lines
package ikari_video_pkg;

    // Screen geometry
    localparam integer H_TOTAL     = 384;
    localparam integer H_ACTIVE    = 256;
    localparam integer HSYNC_START = 288;
    localparam integer HSYNC_END   = 320;
    localparam integer V_TOTAL     = 264;
    localparam integer V_ACTIVE    = 224;
    localparam integer VSYNC_START = 240;
    localparam integer VSYNC_END   = 244;

    localparam integer COORD_W     = 9;  // Counters and map coordinates
    localparam integer IDX_W       = 8;  // Layer colour index
    localparam integer SIDE_BANK_W = 3;
    localparam integer LAYER_EN_W  = 4;
    localparam integer AXI_ADDR_W  = 8;
    localparam integer AXI_DATA_W  = 32;

    localparam logic [3:0] TRANSPARENT_NIB = 4'hF;
    localparam logic [1:0] RESP_OKAY       = 2'b00;

    // Register map, byte addresses
    localparam logic [AXI_ADDR_W-1:0] ADDR_SCROLL_X = 8'h00;
    localparam logic [AXI_ADDR_W-1:0] ADDR_SCROLL_Y = 8'h04;
    localparam logic [AXI_ADDR_W-1:0] ADDR_ATTR     = 8'h08;  // Bit 0 flip, bits 3:1 side bank
    localparam logic [AXI_ADDR_W-1:0] ADDR_LAYER_EN = 8'h0C;  // back1, front2, front1, side

    localparam logic [LAYER_EN_W-1:0] LAYER_EN_RESET = 4'hF;

    typedef enum logic [2:0] {
        REG_SCROLL_X,
        REG_SCROLL_Y,
        REG_ATTR,
        REG_LAYER_EN,
        REG_NONE
    } reg_addr_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRESP,
        ST_RRESP
    } axil_state_e;

    // Source of the final pixel
    typedef enum logic [2:0] {
        LAYER_NONE,
        LAYER_BACK1,
        LAYER_FRONT2,
        LAYER_FRONT1,
        LAYER_SIDE
    } layer_e;

    typedef struct packed {
        logic                  en;
        reg_addr_e             target;
        logic [AXI_DATA_W-1:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic [COORD_W-1:0]     scroll_x;
        logic [COORD_W-1:0]     scroll_y;
        logic                   flip;
        logic [SIDE_BANK_W-1:0] side_bank;
        logic [LAYER_EN_W-1:0]  layer_en;
    } video_cfg_t;

    typedef struct packed {
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
        logic               hblank;
        logic               vblank;
        logic               hsync;
        logic               vsync;
        logic               disp;
    } video_pos_t;

    typedef struct packed {
        logic [3:0]       side;
        logic [IDX_W-1:0] front1;
        logic [IDX_W-1:0] front2;
        logic [IDX_W-1:0] back1;
    } layer_pix_t;

    typedef struct packed {
        layer_e           src;
        logic [IDX_W-1:0] index;
    } color_t;

    // Exact match only, anything else is unmapped
    function automatic reg_addr_e decode_addr(input logic [AXI_ADDR_W-1:0] addr);
        reg_addr_e target;
        case (addr)
            ADDR_SCROLL_X: target = REG_SCROLL_X;
            ADDR_SCROLL_Y: target = REG_SCROLL_Y;
            ADDR_ATTR:     target = REG_ATTR;
            ADDR_LAYER_EN: target = REG_LAYER_EN;
            default:       target = REG_NONE;
        endcase
        return target;
    endfunction

endpackage
